/* eth_pkg.sv */
`default_nettype none

package eth_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // first byte on the wire sits in the msbs
    typedef struct packed {
        mac_addr_t   dst_mac;
        mac_addr_t   src_mac;
        logic [15:0] ethertype;
        byte_t       ver_ihl;
        byte_t       tos;
        logic [15:0] total_length;
        logic [15:0] ident;
        logic [15:0] flags_frag;
        byte_t       ttl;
        byte_t       protocol;
        logic [15:0] ip_checksum;
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
        udp_port_t   src_port;
        udp_port_t   dst_port;
        logic [15:0] udp_length;
        logic [15:0] udp_checksum;
    } eth_header_t;

    localparam logic [63:0] PREAMBLE_SFD = 64'h5555_5555_5555_55D5;

    localparam int HEADER_BYTES        = 42;  // eth + ipv4 + udp
    localparam int IP_UDP_HEADER_BYTES = 28;
    localparam int FCS_BYTES           = 4;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam byte_t       IP_PROTO_UDP   = 8'd17;
    localparam mac_addr_t   MAC_BROADCAST  = 48'hFFFF_FFFF_FFFF;

endpackage

`default_nettype wire

/* rx_stream_pkg.sv */
`default_nettype none

package rx_stream_pkg;

    import eth_pkg::*;

    // byte between align and parser
    typedef struct packed {
        byte_t data;
        logic  valid;
        logic  sof;  // first byte after sfd
        logic  eof;  // valid low, dv just fell
    } rx_byte_t;

    // payload byte into the fifo
    typedef struct packed {
        byte_t data;
        logic  valid;
        logic  last;
    } payload_t;

    localparam int FIFO_DEPTH     = 2048;
    localparam int FIFO_ADDR_BITS = 11;

    typedef logic [FIFO_ADDR_BITS-1:0] fifo_addr_t;
    typedef logic [15:0]               count_t;

endpackage

`default_nettype wire

/* gmii_rx_align.sv */
`timescale 1ns/10ps
`default_nettype none

module gmii_rx_align
    import eth_pkg::*, rx_stream_pkg::*;
(
    input  wire        clk_i,
    input  wire        rst_i,
    input  wire byte_t rx_d_i,
    input  wire        rx_dv_i,
    output rx_byte_t   align_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SYNC,
        ST_PASS
    } align_state_e;

    align_state_e state_q;
    byte_t [1:0]  d_q;         // [0] is the input register
    logic  [2:0]  dv_q;
    logic  [63:0] window_q;
    logic  [63:0] window_next;
    logic  [2:0]  sync_cnt_q;
    logic         first_q;
    logic         dv_rise;
    logic         dv_fall;

    assign dv_rise     = dv_q[1] & ~dv_q[2];
    assign dv_fall     = ~dv_q[1] & dv_q[2];
    assign window_next = {window_q[55:0], d_q[1]};

    always_ff @(posedge clk_i) begin
        d_q          <= {d_q[0], rx_d_i};
        window_q     <= window_next;
        align_o.data <= d_q[1];
        if (rst_i) begin
            dv_q          <= '0;
            state_q       <= ST_IDLE;
            sync_cnt_q    <= '0;
            first_q       <= 1'b0;
            align_o.valid <= 1'b0;
            align_o.sof   <= 1'b0;
            align_o.eof   <= 1'b0;
        end else begin
            dv_q          <= {dv_q[1:0], rx_dv_i};
            align_o.valid <= 1'b0;
            align_o.sof   <= 1'b0;
            align_o.eof   <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (dv_rise) begin
                        state_q    <= ST_SYNC;
                        sync_cnt_q <= 3'd1;  // first preamble byte already in window
                    end
                end
                ST_SYNC: begin
                    if (!dv_q[1]) begin
                        state_q <= ST_IDLE;  // runt, no sof seen
                    end else begin
                        sync_cnt_q <= sync_cnt_q + 3'd1;
                        if (sync_cnt_q == 3'd7) begin
                            state_q <= (window_next == PREAMBLE_SFD) ? ST_PASS : ST_IDLE;
                            first_q <= 1'b1;
                        end
                    end
                end
                ST_PASS: begin
                    if (dv_fall) begin
                        align_o.eof <= 1'b1;
                        state_q     <= ST_IDLE;
                    end else begin
                        align_o.valid <= 1'b1;
                        align_o.sof   <= first_q;
                        first_q       <= 1'b0;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* frame_header_parser.sv */
`timescale 1ns/10ps
`default_nettype none

module frame_header_parser
    import eth_pkg::*, rx_stream_pkg::*;
(
    input  wire            clk_i,
    input  wire            rst_i,
    input  wire rx_byte_t  align_i,
    input  wire mac_addr_t local_mac_i,
    input  wire ip_addr_t  local_ip_i,
    input  wire udp_port_t local_port_i,
    output payload_t       pay_o,
    output logic           frame_drop_o
);

    localparam int HEADER_BITS = HEADER_BYTES * 8;

    typedef enum logic [2:0] {
        P_IDLE,
        P_HEADER,
        P_PAYLOAD,
        P_FCS,
        P_SKIP
    } parse_state_e;

    parse_state_e state_q;
    eth_header_t  hdr_q;
    eth_header_t  hdr_next;
    logic [15:0]  cnt_q;       // header index, payload remaining, fcs index
    logic [15:0]  pay_len;
    byte_t        hold_data_q;
    logic         hold_valid_q;
    logic         mac_ok;
    logic         type_ok;
    logic         proto_ok;
    logic         ip_ok;
    logic         port_ok;
    logic         len_ok;
    logic         frame_ok;

    // checks look at the header including the byte arriving now
    assign hdr_next = {hdr_q[HEADER_BITS-9:0], align_i.data};
    assign pay_len  = hdr_next.total_length - 16'(IP_UDP_HEADER_BYTES);

    assign mac_ok   = (hdr_next.dst_mac == local_mac_i) || (hdr_next.dst_mac == MAC_BROADCAST);
    assign type_ok  = hdr_next.ethertype == ETHERTYPE_IPV4;
    assign proto_ok = hdr_next.protocol == IP_PROTO_UDP;
    assign ip_ok    = hdr_next.dst_ip == local_ip_i;
    assign port_ok  = hdr_next.dst_port == local_port_i;
    assign len_ok   = hdr_next.total_length > 16'(IP_UDP_HEADER_BYTES);  // empty payload dropped
    assign frame_ok = mac_ok & type_ok & proto_ok & ip_ok & port_ok & len_ok;

    always_ff @(posedge clk_i) begin
        pay_o.data <= hold_data_q;
        if (align_i.valid && (state_q == P_IDLE || state_q == P_HEADER)) begin
            hdr_q <= hdr_next;
        end
        if (align_i.valid && state_q == P_PAYLOAD) begin
            hold_data_q <= align_i.data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q      <= P_IDLE;
            cnt_q        <= '0;
            hold_valid_q <= 1'b0;
            pay_o.valid  <= 1'b0;
            pay_o.last   <= 1'b0;
            frame_drop_o <= 1'b0;
        end else begin
            pay_o.valid  <= 1'b0;
            pay_o.last   <= 1'b0;
            frame_drop_o <= 1'b0;
            case (state_q)
                P_IDLE: begin
                    if (align_i.valid && align_i.sof) begin
                        state_q <= P_HEADER;
                        cnt_q   <= 16'd1;
                    end
                end
                P_HEADER: begin
                    if (align_i.eof) begin
                        frame_drop_o <= 1'b1;  // short header
                        state_q      <= P_IDLE;
                    end else if (align_i.valid) begin
                        cnt_q <= cnt_q + 16'd1;
                        if (cnt_q == 16'(HEADER_BYTES - 1)) begin
                            if (frame_ok) begin
                                state_q <= P_PAYLOAD;
                                cnt_q   <= pay_len;
                            end else begin
                                state_q      <= P_SKIP;
                                frame_drop_o <= 1'b1;
                            end
                        end
                    end
                end
                P_PAYLOAD: begin
                    if (align_i.eof) begin
                        // cut short, close with what we have
                        pay_o.valid  <= hold_valid_q;
                        pay_o.last   <= hold_valid_q;
                        frame_drop_o <= ~hold_valid_q;
                        hold_valid_q <= 1'b0;
                        state_q      <= P_IDLE;
                    end else if (align_i.valid) begin
                        pay_o.valid  <= hold_valid_q;  // release previous byte
                        hold_valid_q <= 1'b1;
                        cnt_q        <= cnt_q - 16'd1;
                        if (cnt_q == 16'd1) begin
                            state_q <= P_FCS;
                            cnt_q   <= '0;
                        end
                    end
                end
                P_FCS: begin
                    if (hold_valid_q) begin
                        pay_o.valid  <= 1'b1;  // final byte with last
                        pay_o.last   <= 1'b1;
                        hold_valid_q <= 1'b0;
                    end
                    if (align_i.eof) begin
                        state_q <= P_IDLE;
                    end else if (align_i.valid) begin
                        cnt_q <= cnt_q + 16'd1;
                        if (cnt_q == 16'(FCS_BYTES - 1)) begin
                            state_q <= P_SKIP;
                        end
                    end
                end
                P_SKIP: begin
                    if (align_i.eof) begin
                        state_q <= P_IDLE;
                    end
                end
                default: state_q <= P_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* payload_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module payload_fifo
    import eth_pkg::*, rx_stream_pkg::*;
(
    input  wire           clk_i,
    input  wire           rst_i,
    input  wire payload_t pay_i,
    output byte_t         m_data_o,
    output logic          m_last_o,
    output logic          m_valid_o,
    input  wire           m_ready_i,
    output logic          overflow_o
);

    logic [8:0] mem [FIFO_DEPTH];  // {last, data}
    fifo_addr_t wr_addr_q;
    fifo_addr_t rd_addr_q;
    logic       wr_wrap_q;
    logic       rd_wrap_q;
    logic       full;
    logic       empty;
    logic       wr_en;
    logic       rd_en;

    assign full  = (wr_addr_q == rd_addr_q) && (wr_wrap_q != rd_wrap_q);
    assign empty = (wr_addr_q == rd_addr_q) && (wr_wrap_q == rd_wrap_q);
    assign wr_en = pay_i.valid && !full;
    // refill the output slot when it is empty or being taken
    assign rd_en = !empty && (!m_valid_o || m_ready_i);

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_addr_q] <= {pay_i.last, pay_i.data};
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            {m_last_o, m_data_o} <= mem[rd_addr_q];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_addr_q  <= '0;
            wr_wrap_q  <= 1'b0;
            rd_addr_q  <= '0;
            rd_wrap_q  <= 1'b0;
            m_valid_o  <= 1'b0;
            overflow_o <= 1'b0;
        end else begin
            overflow_o <= pay_i.valid && full;  // byte lost
            if (wr_en) begin
                {wr_wrap_q, wr_addr_q} <= {wr_wrap_q, wr_addr_q} + 1'b1;
            end
            if (rd_en) begin
                {rd_wrap_q, rd_addr_q} <= {rd_wrap_q, rd_addr_q} + 1'b1;
                m_valid_o              <= 1'b1;
            end else if (m_ready_i) begin
                m_valid_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* udp_rx_top.sv */
`timescale 1ns/10ps
`default_nettype none

module udp_rx_top
    import eth_pkg::*, rx_stream_pkg::*;
(
    input  wire            clk_i,
    input  wire            rst_i,
    input  wire byte_t     rx_d_i,
    input  wire            rx_dv_i,
    input  wire mac_addr_t local_mac_i,
    input  wire ip_addr_t  local_ip_i,
    input  wire udp_port_t local_port_i,
    output byte_t          m_data_o,
    output logic           m_last_o,
    output logic           m_valid_o,
    input  wire            m_ready_i,
    output count_t         dropped_count_o,
    output count_t         overflow_count_o
);

    rx_byte_t align_q;
    payload_t pay_q;
    logic     frame_drop;
    logic     overflow;

    // saturating increment for the status counters
    function automatic count_t sat_inc(input count_t count, input logic pulse);
        if (pulse && count != '1) begin
            return count + count_t'(1);
        end
        return count;
    endfunction

    gmii_rx_align gmii_rx_align_inst (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .rx_d_i (rx_d_i),
        .rx_dv_i(rx_dv_i),
        .align_o(align_q)
    );

    frame_header_parser frame_header_parser_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .align_i     (align_q),
        .local_mac_i (local_mac_i),
        .local_ip_i  (local_ip_i),
        .local_port_i(local_port_i),
        .pay_o       (pay_q),
        .frame_drop_o(frame_drop)
    );

    payload_fifo payload_fifo_inst (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .pay_i     (pay_q),
        .m_data_o  (m_data_o),
        .m_last_o  (m_last_o),
        .m_valid_o (m_valid_o),
        .m_ready_i (m_ready_i),
        .overflow_o(overflow)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dropped_count_o  <= '0;
            overflow_count_o <= '0;
        end else begin
            dropped_count_o  <= sat_inc(dropped_count_o, frame_drop);
            overflow_count_o <= sat_inc(overflow_count_o, overflow);
        end
    end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    localparam int RESET_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;  // 10 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

/* tb_udp_rx_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_udp_rx_asserts
    import eth_pkg::*, rx_stream_pkg::*;
(
    input wire           clk_i,
    input wire           rst_i,
    input wire           valid_i,
    input wire           ready_i,
    input wire byte_t    data_i,
    input wire           last_i,
    input wire payload_t pay_i,
    input wire           frame_drop_i
);

    int fail_count = 0;  // read by the testbench at the end

    valid_low_in_reset: assert property (@(posedge clk_i) rst_i |=> !valid_i)
        else begin
            $error("output valid high after a reset cycle");
            fail_count++;
        end

    // output slot holds still until the byte is taken
    held_while_stalled: assert property (@(posedge clk_i) disable iff (rst_i)
        valid_i && !ready_i |=> valid_i && $stable(data_i) && $stable(last_i))
        else begin
            $error("output stream changed while valid and not ready");
            fail_count++;
        end

    drop_without_payload: assert property (@(posedge clk_i) disable iff (rst_i)
        !(frame_drop_i && pay_i.valid))
        else begin
            $error("frame drop pulse together with a payload byte");
            fail_count++;
        end

endmodule

`default_nettype wire

/* tb_udp_rx.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_udp_rx
    import eth_pkg::*, rx_stream_pkg::*;
();

    localparam int NUM_FRAMES       = 150;
    localparam int STALL_FIRST      = 50;  // ready held low for these frames
    localparam int STALL_LAST       = 64;
    localparam int CYCLES_PER_FRAME = 200;
    localparam int MARGIN_CYCLES    = 5000;
    localparam int SEED             = 73544;

    localparam mac_addr_t LOCAL_MAC  = 48'h02_00_5E_10_20_30;
    localparam ip_addr_t  LOCAL_IP   = 32'hC0A8_010A;
    localparam udp_port_t LOCAL_PORT = 16'd5004;

    // frame kinds
    localparam int K_GOOD        = 0;
    localparam int K_BROADCAST   = 1;
    localparam int K_WRONG_MAC   = 2;
    localparam int K_WRONG_IP    = 3;
    localparam int K_WRONG_PORT  = 4;
    localparam int K_WRONG_PROTO = 5;
    localparam int K_WRONG_TYPE  = 6;
    localparam int K_BAD_SYNC    = 7;
    localparam int K_CUT_HEADER  = 8;
    localparam int K_CUT_PAYLOAD = 9;

    logic   clk;
    logic   rst;
    byte_t  rx_d;
    logic   rx_dv;
    logic   m_ready;
    byte_t  m_data;
    logic   m_last;
    logic   m_valid;
    count_t dropped_count;
    count_t overflow_count;
    logic   stall_ready;

    byte_t      frame_q[$];
    logic [8:0] expected_q[$];  // {last, data}
    int         expected_drops = 0;
    int         errors = 0;
    int         checks = 0;
    int         bytes_out = 0;

    tb_clock_gen tb_clock_gen_inst (
        .clk_o(clk),
        .rst_o(rst)
    );

    udp_rx_top udp_rx_top_inst (
        .clk_i           (clk),
        .rst_i           (rst),
        .rx_d_i          (rx_d),
        .rx_dv_i         (rx_dv),
        .local_mac_i     (LOCAL_MAC),
        .local_ip_i      (LOCAL_IP),
        .local_port_i    (LOCAL_PORT),
        .m_data_o        (m_data),
        .m_last_o        (m_last),
        .m_valid_o       (m_valid),
        .m_ready_i       (m_ready),
        .dropped_count_o (dropped_count),
        .overflow_count_o(overflow_count)
    );

    bind udp_rx_top tb_udp_rx_asserts udp_rx_asserts_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .valid_i     (m_valid_o),
        .ready_i     (m_ready_i),
        .data_i      (m_data_o),
        .last_i      (m_last_o),
        .pay_i       (pay_q),
        .frame_drop_i(frame_drop)
    );

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    // fills frame_q and tells the model what should come out
    task automatic build_frame(input int kind);
        eth_header_t hdr;
        byte_t       body[$];
        byte_t       pre;
        int          pay_len;
        int          keep;
        int          bad_idx;
        int          n_out;

        pay_len          = $urandom_range(64, 1);
        hdr.dst_mac      = LOCAL_MAC;
        hdr.src_mac      = {16'($urandom), $urandom};
        hdr.ethertype    = 16'h0800;
        hdr.ver_ihl      = 8'h45;
        hdr.tos          = 8'h00;
        hdr.total_length = 16'(pay_len + 28);
        hdr.ident        = 16'($urandom);
        hdr.flags_frag   = 16'h4000;
        hdr.ttl          = 8'd64;
        hdr.protocol     = 8'd17;
        hdr.ip_checksum  = 16'($urandom);
        hdr.src_ip       = $urandom;
        hdr.dst_ip       = LOCAL_IP;
        hdr.src_port     = 16'($urandom);
        hdr.dst_port     = LOCAL_PORT;
        hdr.udp_length   = 16'(pay_len + 8);
        hdr.udp_checksum = 16'h0000;
        case (kind)
            K_BROADCAST:   hdr.dst_mac   = 48'hFFFF_FFFF_FFFF;
            K_WRONG_MAC:   hdr.dst_mac   = LOCAL_MAC ^ 48'($urandom_range(32'hFFFF, 1));
            K_WRONG_IP:    hdr.dst_ip    = LOCAL_IP ^ 32'($urandom_range(255, 1));
            K_WRONG_PORT:  hdr.dst_port  = LOCAL_PORT ^ 16'($urandom_range(32'hFFFF, 1));
            K_WRONG_PROTO: hdr.protocol  = 8'd6;      // tcp
            K_WRONG_TYPE:  hdr.ethertype = 16'h86DD;  // ipv6
            default: ;
        endcase

        for (int i = HEADER_BYTES - 1; i >= 0; i--) begin
            body.push_back(hdr[i*8 +: 8]);  // msbs go out first
        end
        for (int i = 0; i < pay_len + FCS_BYTES; i++) begin
            body.push_back(8'($urandom));  // payload, then a random fcs
        end

        keep = body.size();
        if (kind == K_CUT_HEADER) begin
            keep = $urandom_range(HEADER_BYTES - 1, 1);
        end else if (kind == K_CUT_PAYLOAD) begin
            keep = HEADER_BYTES + int'($urandom_range(pay_len, 1));
        end
        bad_idx = -1;
        if (kind == K_BAD_SYNC) begin
            bad_idx = $urandom_range(7, 0);
        end

        frame_q.delete();
        for (int i = 0; i < 8; i++) begin
            pre = PREAMBLE_SFD[63 - 8*i -: 8];
            if (i == bad_idx) begin
                pre = pre ^ 8'($urandom_range(255, 1));
            end
            frame_q.push_back(pre);
        end
        for (int i = 0; i < keep; i++) begin
            frame_q.push_back(body[i]);
        end

        if (kind == K_GOOD || kind == K_BROADCAST || kind == K_CUT_PAYLOAD) begin
            n_out = (kind == K_CUT_PAYLOAD) ? keep - HEADER_BYTES : pay_len;
            for (int i = 0; i < n_out; i++) begin
                expected_q.push_back({i == n_out - 1, body[HEADER_BYTES + i]});
            end
        end else if (kind != K_BAD_SYNC) begin
            expected_drops++;  // filtered, or header cut short
        end
    endtask

    task automatic drive_frame();
        int gap;

        gap = $urandom_range(20, 12);
        foreach (frame_q[i]) begin
            @(posedge clk);
            rx_d  <= frame_q[i];
            rx_dv <= 1'b1;
        end
        @(posedge clk);
        rx_d  <= 8'h00;
        rx_dv <= 1'b0;
        repeat (gap - 1) @(posedge clk);
    endtask

    always @(posedge clk) begin
        if (stall_ready) begin
            m_ready <= 1'b0;
        end else begin
            m_ready <= ($urandom_range(99, 0) >= 30);
        end
    end

    // one expected entry per accepted byte
    always @(posedge clk) begin
        logic [8:0] exp_entry;

        if (!rst && m_valid && m_ready) begin
            bytes_out++;
            if (expected_q.size() == 0) begin
                errors++;
                $display("unexpected output byte 0x%0h at %0t, no byte was expected",
                         m_data, $time);
            end else begin
                exp_entry = expected_q.pop_front();
                check_value("output data", m_data, exp_entry[7:0]);
                check_value("output last", m_last, exp_entry[8]);
            end
        end
    end

    initial begin
        repeat (NUM_FRAMES * CYCLES_PER_FRAME + MARGIN_CYCLES) @(posedge clk);
        $display("timeout: run did not finish, %0d payload bytes never came out",
                 expected_q.size());
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int kind;

        void'($urandom(SEED));
        rx_d        = 8'h00;
        rx_dv       = 1'b0;
        m_ready     = 1'b0;
        stall_ready = 1'b0;
        while (rst !== 1'b0) begin
            @(posedge clk);
        end

        // quiet line after reset
        repeat (20) begin
            @(posedge clk);
            check_value("valid after reset", m_valid, 0);
            check_value("dropped count after reset", dropped_count, 0);
            check_value("overflow count after reset", overflow_count, 0);
        end

        for (int f = 0; f < NUM_FRAMES; f++) begin
            stall_ready <= (f >= STALL_FIRST) && (f < STALL_LAST);
            kind = $urandom_range(11, 0);
            kind = (kind < 3) ? K_GOOD : kind - 2;
            build_frame(kind);
            drive_frame();
            check_value("dropped count after frame", dropped_count, expected_drops);
        end
        stall_ready <= 1'b0;

        while (expected_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (100) @(posedge clk);  // room for stray bytes

        check_value("dropped frame count", dropped_count, expected_drops);
        check_value("overflow count", overflow_count, 0);
        errors += udp_rx_top_inst.udp_rx_asserts_inst.fail_count;

        $display("frames %0d, output bytes %0d, checks %0d, errors %0d",
                 NUM_FRAMES, bytes_out, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
eth_pkg.sv
rx_stream_pkg.sv
gmii_rx_align.sv
frame_header_parser.sv
payload_fifo.sv
udp_rx_top.sv
tb_clock_gen.sv
tb_udp_rx_asserts.sv
tb_udp_rx.sv

/* Makefile */
TOP = tb_udp_rx

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
